// File: char_buffer.sv
`timescale 1ns/1ps
`include "marquee_config.svh"

module char_buffer (
    input  logic                     clk_1khz,
    input  logic                     sys_rst_n,
    input  logic                     char_wr,
    input  marquee_pkg::glyph_code_t char_code,
    input  logic                     restart,
    input  logic [3:0]               base,
    output marquee_pkg::window_t     window
);

    marquee_pkg::glyph_code_t ring [`MARQUEE_MSG_LEN];
    logic [3:0]               wr_ptr;
    marquee_pkg::window_t     window_nxt;

    // ring position offset characters after start, wrapped
    function automatic logic [3:0] ring_idx(input logic [3:0] start,
                                            input int unsigned offset);
        int unsigned sum;
        sum = start + offset;
        if (sum >= `MARQUEE_MSG_LEN) begin
            sum = sum - `MARQUEE_MSG_LEN;
        end
        return 4'(sum);
    endfunction

    // write pointer, back to entry 0 on restart
    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= 4'd0;
        end else if (restart) begin
            wr_ptr <= 4'd0;               // new message starts over
        end else if (char_wr) begin
            if (wr_ptr == 4'(`MARQUEE_MSG_LEN - 1)) begin
                wr_ptr <= 4'd0;
            end else begin
                wr_ptr <= wr_ptr + 4'd1;
            end
        end
    end

    // message storage, blank until written
    // a write coinciding with restart is dropped along with the old pointer
    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < `MARQUEE_MSG_LEN; i++) begin
                ring[i] <= `MARQUEE_BLANK;
            end
        end else if (char_wr && !restart) begin
            ring[wr_ptr] <= char_code;
        end
    end

    // gather the six wrapped entries, leftmost digit from ring[base]
    always_comb begin
        for (int d = 0; d < `MARQUEE_DIGITS; d++) begin
            window_nxt.digit[`MARQUEE_DIGITS - 1 - d] = ring[ring_idx(base, d)];
        end
    end

    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            window.flat <= {`MARQUEE_DIGITS{`MARQUEE_BLANK}};   // all blank
        end else begin
            window <= window_nxt;
        end
    end

endmodule

// File: compile.f
+incdir+.
marquee_pkg.sv
char_buffer.sv
scroll_control.sv
digit_scan.sv
marquee_top.sv
marquee_assertions.sv
marquee_checker.sv
tb_marquee.sv

// File: digit_scan.sv
`timescale 1ns/1ps
`include "marquee_config.svh"

module digit_scan (
    input  logic                 clk_1khz,
    input  logic                 sys_rst_n,
    input  marquee_pkg::window_t window,
    output logic [2:0]           sel,
    output logic [7:0]           seg
);

    logic [2:0]               cur_state;
    logic [2:0]               nxt_state;
    marquee_pkg::glyph_code_t code_q;    // character on the selected digit

    // scan state register
    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cur_state <= 3'd0;
        end else begin
            cur_state <= nxt_state;
        end
    end

    // step through the digits, leftmost first
    always_comb begin
        if (cur_state >= 3'(`MARQUEE_DIGITS - 1)) begin
            nxt_state = 3'd0;                // also recovers from unused states
        end else begin
            nxt_state = cur_state + 3'd1;
        end
    end

    // select the digit and latch its character in the same cycle
    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sel    <= 3'd0;
            code_q <= `MARQUEE_BLANK;
        end else if (cur_state < 3'(`MARQUEE_DIGITS)) begin
            sel    <= cur_state;
            code_q <= window.digit[3'(`MARQUEE_DIGITS - 1) - cur_state];
        end else begin
            sel    <= 3'd0;
            code_q <= `MARQUEE_BLANK;
        end
    end

    // glyph table for a common-anode module, segment order dp g f e d c b a
    // a 0 lights the segment, dp stays dark
    always_comb begin
        case (code_q)
            marquee_pkg::GLYPH_H:     seg = 8'b1000_1001;
            marquee_pkg::GLYPH_E:     seg = 8'b1000_0110;
            marquee_pkg::GLYPH_L:     seg = 8'b1100_0111;
            marquee_pkg::GLYPH_O:     seg = 8'b1100_0000;
            marquee_pkg::GLYPH_P:     seg = 8'b1000_1100;
            marquee_pkg::GLYPH_A:     seg = 8'b1000_1000;
            marquee_pkg::GLYPH_U:     seg = 8'b1100_0001;
            marquee_pkg::GLYPH_C:     seg = 8'b1100_0110;
            marquee_pkg::GLYPH_D:     seg = 8'b1010_0001;   // b c d e g
            marquee_pkg::GLYPH_N:     seg = 8'b1010_1011;   // c e g
            marquee_pkg::GLYPH_R:     seg = 8'b1010_1111;   // e g
            marquee_pkg::GLYPH_T:     seg = 8'b1000_0111;   // d e f g
            marquee_pkg::GLYPH_DASH:  seg = 8'b1011_1111;   // middle bar only
            marquee_pkg::GLYPH_UNDER: seg = 8'b1111_0111;   // bottom bar only
            marquee_pkg::GLYPH_Y:     seg = 8'b1001_0001;
            marquee_pkg::GLYPH_BLANK: seg = 8'b1111_1111;
            default:                  seg = 8'b1111_1111;
        endcase
    end

endmodule

// File: marquee_assertions.sv
`timescale 1ns/1ps

module marquee_assertions (
    input logic       clk_1khz,
    input logic       sys_rst_n,
    input logic [2:0] sel,
    input logic [7:0] seg
);

    // only digits 0 to 5 exist
    sel_in_range: assert property (
        @(posedge clk_1khz) disable iff (!sys_rst_n) sel <= 3'd5
    ) else $error("digit select %0d is past the last digit", sel);

    // sel holds 0 for one extra cycle right after reset
    sel_steps: assert property (
        @(posedge clk_1khz) disable iff (!sys_rst_n)
        ($past(sys_rst_n) && $past(sys_rst_n, 2) && $past(sys_rst_n, 3)) |->
            sel == (($past(sel) == 3'd5) ? 3'd0 : $past(sel) + 3'd1)
    ) else $error("digit select did not advance by one, now %0d", sel);

    dp_dark: assert property (
        @(posedge clk_1khz) seg[7]
    ) else $error("decimal point driven low, seg %b", seg);

endmodule

// File: marquee_checker.sv
`timescale 1ns/1ps
`include "marquee_config.svh"

module marquee_checker (
    input  logic        clk_1khz,
    input  logic        sys_rst_n,
    input  logic [2:0]  sel,
    input  logic [7:0]  seg,
    input  logic        sample_req,
    input  logic [95:0] test_name,
    input  logic [23:0] expected,
    output logic        frame_done,
    output int          tests_done,
    output int          error_count
);

    // seg pattern back to glyph code, -1 when nothing matches
    // order dp g f e d c b a, low lights a segment
    function automatic int seg_to_code(input logic [7:0] pattern);
        case (pattern)
            8'h89:   return 0;    // H
            8'h86:   return 1;    // E
            8'hC7:   return 2;    // L
            8'hC0:   return 3;    // O
            8'h8C:   return 4;    // P
            8'h88:   return 5;    // A
            8'hC1:   return 6;    // U
            8'hC6:   return 7;    // C
            8'hA1:   return 8;    // d
            8'hAB:   return 9;    // n
            8'hAF:   return 10;   // r
            8'h87:   return 11;   // t
            8'hBF:   return 12;   // dash
            8'hF7:   return 13;   // underscore
            8'h91:   return 14;   // y
            8'hFF:   return 15;   // blank
            default: return -1;
        endcase
    endfunction

    // six consecutive digits, sampled on the falling edge
    task automatic collect_and_compare();
        logic [23:0] shown;
        logic [5:0]  seen;
        int          code;
        logic        readable;
        shown    = 24'hFFFFFF;
        seen     = 6'b0;
        readable = 1'b1;
        for (int i = 0; i < `MARQUEE_DIGITS; i++) begin
            if (i != 0) begin
                @(negedge clk_1khz);
            end
            code = seg_to_code(seg);
            if (sel > 3'd5) begin
                $display("  %s digit select %0d is out of range", test_name, sel);
                readable = 1'b0;
            end else if (code < 0) begin
                $display("  %s segment pattern %b on digit %0d is no glyph",
                         test_name, seg, sel);
                readable = 1'b0;
            end else begin
                seen[sel]            = 1'b1;
                shown[23 - 4*sel -: 4] = 4'(code);   // sel 0 is the leftmost digit
            end
        end
        if (seen != 6'b11_1111) begin
            $display("  %s some digits were not scanned within six cycles", test_name);
            readable = 1'b0;
        end
        tests_done++;
        if (!readable) begin
            error_count++;
            $display("error in %s, the display scan could not be read", test_name);
        end else if (shown != expected) begin
            error_count++;
            $display("Fail %s expected %h actual %h", test_name, expected, shown);
        end else begin
            $display("ok   %s frame %h", test_name, shown);
        end
    endtask

    initial begin
        frame_done  = 1'b0;
        tests_done  = 0;
        error_count = 0;
        forever begin
            @(negedge clk_1khz);
            if (sample_req && !frame_done && sys_rst_n) begin
                collect_and_compare();
                frame_done = 1'b1;
            end else if (!sample_req) begin
                frame_done = 1'b0;   // request withdrawn
            end
        end
    end

endmodule

// File: marquee_config.svh
`ifndef MARQUEE_CONFIG_SVH
`define MARQUEE_CONFIG_SVH

// message ring depth in characters
`define MARQUEE_MSG_LEN 16

// enabled clock cycles between two scroll steps
`define MARQUEE_SCROLL_DIV 8

// digits on the seven-segment module
`define MARQUEE_DIGITS 6

// blank glyph, the ring holds this after reset
`define MARQUEE_BLANK 4'hF

`endif

// File: marquee_pkg.sv
`include "marquee_config.svh"

package marquee_pkg;

    typedef logic [3:0] glyph_code_t;   // one character on one digit

    // character codes, in table order
    localparam glyph_code_t GLYPH_H      = 4'd0;
    localparam glyph_code_t GLYPH_E      = 4'd1;
    localparam glyph_code_t GLYPH_L      = 4'd2;
    localparam glyph_code_t GLYPH_O      = 4'd3;
    localparam glyph_code_t GLYPH_P      = 4'd4;
    localparam glyph_code_t GLYPH_A      = 4'd5;
    localparam glyph_code_t GLYPH_U      = 4'd6;
    localparam glyph_code_t GLYPH_C      = 4'd7;
    localparam glyph_code_t GLYPH_D      = 4'd8;   // lower case d
    localparam glyph_code_t GLYPH_N      = 4'd9;   // lower case n
    localparam glyph_code_t GLYPH_R      = 4'd10;  // lower case r
    localparam glyph_code_t GLYPH_T      = 4'd11;  // lower case t
    localparam glyph_code_t GLYPH_DASH   = 4'd12;
    localparam glyph_code_t GLYPH_UNDER  = 4'd13;
    localparam glyph_code_t GLYPH_Y      = 4'd14;
    localparam glyph_code_t GLYPH_BLANK  = `MARQUEE_BLANK;

    // six visible characters
    // digit[5] is the leftmost position and sits in flat[23:20]
    typedef union packed {
        logic [`MARQUEE_DIGITS*4-1:0]           flat;
        glyph_code_t [`MARQUEE_DIGITS-1:0]      digit;
    } window_t;

endpackage

// File: marquee_top.sv
`timescale 1ns/1ps

module marquee_top (
    input  logic                     clk_1khz,
    input  logic                     sys_rst_n,
    input  logic                     char_wr,
    input  marquee_pkg::glyph_code_t char_code,
    input  logic                     scroll_en,
    input  logic                     restart,
    output logic [2:0]               sel,
    output logic [7:0]               seg
);

    logic [3:0]           base;     // ring index of the leftmost digit
    marquee_pkg::window_t window;   // characters currently on display

    // message ring and window assembly
    char_buffer u_char_buffer (
        .clk_1khz  (clk_1khz),
        .sys_rst_n (sys_rst_n),
        .char_wr   (char_wr),
        .char_code (char_code),
        .restart   (restart),
        .base      (base),
        .window    (window)
    );

    // scroll timing
    scroll_control u_scroll_control (
        .clk_1khz  (clk_1khz),
        .sys_rst_n (sys_rst_n),
        .scroll_en (scroll_en),
        .restart   (restart),
        .base      (base)
    );

    // multiplexed display drive
    digit_scan u_digit_scan (
        .clk_1khz  (clk_1khz),
        .sys_rst_n (sys_rst_n),
        .window    (window),
        .sel       (sel),
        .seg       (seg)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the marquee testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_marquee \
    -f compile.f

# output goes to the terminal and to the log
./obj_dir/Vtb_marquee | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "marquee simulation passed"
else
    echo "marquee simulation failed, see sim.log"
    exit 1
fi

// File: scroll_control.sv
`timescale 1ns/1ps
`include "marquee_config.svh"

module scroll_control (
    input  logic       clk_1khz,
    input  logic       sys_rst_n,
    input  logic       scroll_en,
    input  logic       restart,
    output logic [3:0] base
);

    logic [3:0] prescale;   // enabled cycles since the last step
    logic       step;

    // last enabled cycle of a scroll period
    assign step = scroll_en && (prescale == 4'(`MARQUEE_SCROLL_DIV - 1));

    // prescaler only counts while scrolling is enabled
    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            prescale <= 4'd0;
        end else if (restart) begin
            prescale <= 4'd0;                // restart wins over scroll_en
        end else if (scroll_en) begin
            if (step) begin
                prescale <= 4'd0;
            end else begin
                prescale <= prescale + 4'd1;
            end
        end
    end

    // window base pointer into the ring
    always_ff @(posedge clk_1khz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            base <= 4'd0;
        end else if (restart) begin
            base <= 4'd0;
        end else if (step) begin
            if (base == 4'(`MARQUEE_MSG_LEN - 1)) begin
                base <= 4'd0;                // wrap around the message
            end else begin
                base <= base + 4'd1;
            end
        end
    end

endmodule

// File: tb_marquee.sv
`timescale 1ns/1ps
`include "marquee_config.svh"

module tb_marquee;

    localparam int NUM_ROWS      = 10;
    localparam int SETTLE_CYCLES = 12;   // two cycles to window plus one full scan with slack
    localparam int TIMEOUT_CYCLES = NUM_ROWS *
        (SETTLE_CYCLES + `MARQUEE_DIGITS + `MARQUEE_MSG_LEN * `MARQUEE_SCROLL_DIV) + 100;

    localparam int OP_NONE    = 0;   // only look at the display
    localparam int OP_WRITE   = 1;
    localparam int OP_SCROLL  = 2;   // restart and then scroll count steps
    localparam int OP_RESTART = 3;
    localparam int OP_RANDOM  = 4;   // restart and then write six LFSR codes

    logic                     clk_1khz;
    logic                     sys_rst_n;
    logic                     char_wr;
    marquee_pkg::glyph_code_t char_code;
    logic                     scroll_en;
    logic                     restart;
    logic [2:0]               sel;
    logic [7:0]               seg;

    // request and result lines to the checker
    logic        sample_req;
    logic [95:0] check_name;
    logic [23:0] check_expect;
    logic        frame_done;
    int          tests_done;
    int          error_count;

    // stimulus table with one entry per test
    logic [95:0] row_name   [NUM_ROWS];
    int          row_op     [NUM_ROWS];
    int          row_count  [NUM_ROWS];
    logic [63:0] row_data   [NUM_ROWS];   // codes to write with the first one in the top nibble
    logic [23:0] row_expect [NUM_ROWS];   // six codes with the leftmost digit in the top nibble
    int          row_total;

    logic [7:0]  lfsr_state;
    int          cycle_count;

    marquee_top uut (
        .clk_1khz  (clk_1khz),
        .sys_rst_n (sys_rst_n),
        .char_wr   (char_wr),
        .char_code (char_code),
        .scroll_en (scroll_en),
        .restart   (restart),
        .sel       (sel),
        .seg       (seg)
    );

    marquee_checker u_checker (
        .clk_1khz    (clk_1khz),
        .sys_rst_n   (sys_rst_n),
        .sel         (sel),
        .seg         (seg),
        .sample_req  (sample_req),
        .test_name   (check_name),
        .expected    (check_expect),
        .frame_done  (frame_done),
        .tests_done  (tests_done),
        .error_count (error_count)
    );

    bind digit_scan marquee_assertions u_scan_assertions (
        .clk_1khz  (clk_1khz),
        .sys_rst_n (sys_rst_n),
        .sel       (sel),
        .seg       (seg)
    );

    initial begin
        clk_1khz = 1'b0;
        forever #10 clk_1khz = ~clk_1khz;
    end

    // galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    task automatic random_code(output marquee_pkg::glyph_code_t code);
        code = 4'd0;
        for (int b = 0; b < 4; b++) begin
            code       = {code[2:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic add_row(input logic [95:0] name, input int op, input int count,
                           input logic [63:0] data, input logic [23:0] frame);
        row_name[row_total]   = name;
        row_op[row_total]     = op;
        row_count[row_total]  = count;
        row_data[row_total]   = data;
        row_expect[row_total] = frame;
        row_total++;
    endtask

    // scroll rows restart first, which also rewinds the write pointer
    task automatic load_table();
        row_total = 0;
        add_row("reset       ", OP_NONE,    0,  64'h0, {6{`MARQUEE_BLANK}});
        add_row("write_hello ", OP_WRITE,   6,  64'h0122_3F00_0000_0000, 24'h01223F);
        add_row("scroll_two  ", OP_SCROLL,  2,  64'h0, 24'h223FFF);   // base 2
        add_row("fill_ring   ", OP_WRITE,   16, 64'h0123_4567_89AB_CDEF, 24'h234567);
        add_row("scroll_mid  ", OP_SCROLL,  8,  64'h0, 24'h89ABCD);
        add_row("wrap        ", OP_SCROLL,  14, 64'h0, 24'hEF0123);   // base 14 wraps to entry 0
        // leaves the write pointer on entry 1 ahead of the restart
        add_row("write_head  ", OP_WRITE,   1,  64'hC000_0000_0000_0000, 24'hEFC123);
        add_row("restart     ", OP_RESTART, 0,  64'h0, 24'hC12345);
        add_row("rewrite_head", OP_WRITE,   1,  64'h7000_0000_0000_0000, 24'h712345);
        add_row("random      ", OP_RANDOM,  6,  64'h0, 24'h000000);   // filled in when run
    endtask

    task automatic pulse_restart();
        @(posedge clk_1khz);
        restart <= 1'b1;
        @(posedge clk_1khz);
        restart <= 1'b0;
    endtask

    task automatic write_codes(input logic [63:0] data, input int count);
        for (int j = 0; j < count; j++) begin
            @(posedge clk_1khz);
            char_wr   <= 1'b1;
            char_code <= data[63 - 4*j -: 4];
        end
        @(posedge clk_1khz);
        char_wr <= 1'b0;
    endtask

    task automatic scroll_steps(input int steps);
        @(posedge clk_1khz);
        scroll_en <= 1'b1;
        repeat (steps * `MARQUEE_SCROLL_DIV) @(posedge clk_1khz);
        scroll_en <= 1'b0;
    endtask

    task automatic run_row(input int r);
        marquee_pkg::glyph_code_t code;
        logic [63:0]              data;
        case (row_op[r])
            OP_WRITE: write_codes(row_data[r], row_count[r]);
            OP_SCROLL: begin
                pulse_restart();
                scroll_steps(row_count[r]);
            end
            OP_RESTART: pulse_restart();
            OP_RANDOM: begin
                data = 64'h0;
                for (int j = 0; j < row_count[r]; j++) begin
                    random_code(code);
                    data[63 - 4*j -: 4] = code;
                end
                row_expect[r] = data[63:40];   // base 0 shows the first six writes
                pulse_restart();
                write_codes(data, row_count[r]);
            end
            default: ;
        endcase
    endtask

    // four-phase exchange with the checker
    task automatic sample_frame(input int r);
        check_name   <= row_name[r];
        check_expect <= row_expect[r];
        sample_req   <= 1'b1;
        @(posedge clk_1khz);
        while (!frame_done) @(posedge clk_1khz);
        sample_req <= 1'b0;
        @(posedge clk_1khz);
        while (frame_done) @(posedge clk_1khz);
    endtask

    initial begin
        sys_rst_n    <= 1'b0;
        char_wr      <= 1'b0;
        char_code    <= 4'd0;
        scroll_en    <= 1'b0;
        restart      <= 1'b0;
        sample_req   <= 1'b0;
        check_name   <= 96'h0;
        check_expect <= 24'h0;
        lfsr_state = 8'd79;
        load_table();
        repeat (4) @(posedge clk_1khz);
        sys_rst_n <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
            repeat (SETTLE_CYCLES) @(posedge clk_1khz);
            sample_frame(r);
        end
        if (tests_done != NUM_ROWS) begin
            $display("only %0d of %0d frames were checked", tests_done, NUM_ROWS);
        end
        $display("%0d tests checked, %0d failed", tests_done, error_count);
        if (error_count == 0 && tests_done == NUM_ROWS) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_1khz);
            cycle_count++;
        end
        $display("run stopped, no result after %0d clock cycles", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
